// File: compile.f
hw/synth_pkg.sv
hw/midi_uart_rx.sv
hw/midi_decoder.sv
hw/synth_engine.sv
hw/voice_mixer.sv
hw/synth_regs.sv
hw/synthesizer.sv
testbench/tb_synthesizer.sv

// File: testbench/tb_synthesizer.sv
//////////////////////////////////////////////////////////////////////
// testbench for the midi synthesizer; drives serial midi, cpu and trig
// against a voice table model, assertions do the checking
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_synthesizer
    import synth_pkg::*;
();

    localparam int VOICES       = 8;
    localparam int CLKS_PER_BIT = 8;            // fast midi for simulation
    localparam int AMP_SHIFT    = 8;

    logic               reg_clk;
    logic               reg_reset_N;
    logic               midi_rxd;
    logic               trig;
    logic               cpu_write;
    logic               cpu_read;
    logic [3:0]         cpu_address;
    logic [7:0]         cpu_wdata;
    logic [7:0]         cpu_rdata;
    logic [VOICES-1:0]  keys_on;
    logic signed [23:0] lsound_out;
    logic signed [23:0] rsound_out;

    // reference model of the voice table
    logic               exp_on  [VOICES];
    logic [KEY_W-1:0]   exp_key [VOICES];
    logic [VEL_W-1:0]   exp_vel [VOICES];
    logic [15:0]        phase   [VOICES];       // square sign is the top bit
    logic [BEND_W-1:0]  exp_bend;
    logic [31:0]        rng_state = 32'h6dd8_3f4c;

    synthesizer #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (
        .reg_clk    (reg_clk),    .reg_reset_N (reg_reset_N),
        .midi_rxd   (midi_rxd),   .trig        (trig),
        .cpu_write  (cpu_write),  .cpu_read    (cpu_read),
        .cpu_address(cpu_address),.cpu_wdata   (cpu_wdata),
        .cpu_rdata  (cpu_rdata),  .keys_on     (keys_on),
        .lsound_out (lsound_out), .rsound_out  (rsound_out)
    );

    initial begin
        reg_clk = 1'b0;
        forever #10 reg_clk = ~reg_clk;     // 20 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // error exits
    task automatic stop_with_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout after 50 cycles waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped on timeout");
    endtask

    // read data only moves after a read, audio only after trig
    a_rdata_hold : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        !cpu_read |=> $stable(cpu_rdata))
        else stop_with_error("cpu_rdata changed without a read");
    a_audio_hold : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        !trig |=> $stable(lsound_out) && $stable(rsound_out))
        else stop_with_error("audio output changed without trig");
    a_keys_timing : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        $changed(keys_on) |-> ($past(dut.rx_valid, 2) || $past(dut.rx_valid, 3) ||
                               $past(dut.rx_valid, 4) || $past(dut.rx_valid, 5)))
        else stop_with_error("keys_on changed too long after the last midi byte");

    //////////////////////////////////////////////////////////////////////
    // model
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [6:0] next_velocity();
        rng_state = lcg_step(rng_state);
        return (rng_state[30:24] == 7'd0) ? 7'd1 : rng_state[30:24];   // never zero
    endfunction

    function automatic logic [VOICES-1:0] model_keys();
        logic [VOICES-1:0] k;
        for (int v = 0; v < VOICES; v++)
            k[v] = exp_on[v];
        return k;
    endfunction

    function automatic void release_key(input logic [6:0] key);
        for (int v = 0; v < VOICES; v++)
            if (exp_on[v] && exp_key[v] == key)
                exp_on[v] = 1'b0;
    endfunction

    function automatic void press_key(input logic [6:0] key, input logic [6:0] vel);
        int hit;
        int free;
        hit  = -1;
        free = -1;
        for (int v = VOICES - 1; v >= 0; v--) begin     // lowest index wins
            if (exp_on[v] && exp_key[v] == key)
                hit = v;
            if (!exp_on[v])
                free = v;
        end
        if (vel == 7'd0)
            release_key(key);                   // velocity 0 means note off
        else if (hit >= 0)
            exp_vel[hit] = vel;                 // retrigger only
        else if (free >= 0) begin
            exp_on[free]  = 1'b1;
            exp_key[free] = key;
            exp_vel[free] = vel;
        end                                     // all busy, note lost
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge reg_clk);
            #2 midi_rxd = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge reg_clk);
        end
    endtask

    task automatic send_message(input logic [7:0] status, input logic [7:0] d1,
                                input logic [7:0] d2, input logic running);
        if (!running)
            send_byte(status);
        send_byte(d1);
        send_byte(d2);
    endtask

    task automatic cpu_access(input logic wr, input logic [3:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge reg_clk);
        #2;
        cpu_write   = wr;
        cpu_read    = !wr;
        cpu_address = addr;
        cpu_wdata   = wdata;
        @(posedge reg_clk);
        #2;
        cpu_write = 1'b0;
        cpu_read  = 1'b0;
        rdata     = cpu_rdata;                  // lands a cycle after the read
    endtask

    task automatic pulse_trig();
        int exp_l;
        int exp_r;
        int amp;
        int bend_step;
        exp_l     = 0;
        exp_r     = 0;
        bend_step = (int'(exp_bend) - 8192) >>> 9;
        for (int v = 0; v < VOICES; v++) begin
            amp = exp_on[v] ? int'(exp_vel[v]) << AMP_SHIFT : 0;
            if (phase[v][15])
                amp = -amp;
            if (v % 2 == 0)
                exp_l += amp;                   // even voices left
            else
                exp_r += amp;
        end
        for (int v = 0; v < VOICES; v++)
            phase[v] = exp_on[v] ?
                phase[v] + 16'(((int'(exp_key[v]) + 1) << 4) + bend_step) : 16'd0;
        @(posedge reg_clk);
        #2 trig = 1'b1;
        @(posedge reg_clk);
        #2 trig = 1'b0;
        assert (lsound_out == exp_l)
            else stop_with_error($sformatf("lsound_out %0d, expected %0d", lsound_out, exp_l));
        assert (rsound_out == exp_r)
            else stop_with_error($sformatf("rsound_out %0d, expected %0d", rsound_out, exp_r));
    endtask

    // wait for the voice map, then make sure it stays put
    task automatic expect_keys();
        int n;
        n = 0;
        while (keys_on !== model_keys() && n < 50) begin
            @(posedge reg_clk);
            #2;
            n++;
        end
        if (keys_on !== model_keys())
            timeout_abort("keys_on to match the model");
        repeat (6) @(posedge reg_clk);          // engine settles within 4 cycles
        #2;
        assert (keys_on == model_keys())
            else stop_with_error($sformatf("keys_on %b, expected %b", keys_on, model_keys()));
    endtask

    task automatic play(input logic [7:0] status, input logic [6:0] key,
                        input logic [6:0] vel, input logic running);
        send_message(status, {1'b0, key}, {1'b0, vel}, running);
        if (status[7:4] == 4'h8)
            release_key(key);
        else if (status[3:0] == 4'd3)           // only channel 3 is listened to
            press_key(key, vel);
        expect_keys();
    endtask

    task automatic check_bend();
        logic [7:0] lo;
        logic [7:0] hi;
        cpu_access(1'b0, REG_BEND_LO, 8'h00, lo);
        cpu_access(1'b0, REG_BEND_HI, 8'h00, hi);
        assert ({hi[6:0], lo[6:0]} == exp_bend)
            else stop_with_error($sformatf("bend %0d, expected %0d", {hi[6:0], lo[6:0]}, exp_bend));
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        logic [7:0] rd;
        reg_reset_N = 1'b0;
        midi_rxd    = 1'b1;
        trig        = 1'b0;
        cpu_write   = 1'b0;
        cpu_read    = 1'b0;
        cpu_address = 4'h0;
        cpu_wdata   = 8'h00;
        exp_bend    = BEND_CENTER;
        for (int v = 0; v < VOICES; v++) begin
            exp_on[v]  = 1'b0;
            exp_key[v] = '0;
            exp_vel[v] = '0;
            phase[v]   = 16'd0;
        end
        repeat (5) @(posedge reg_clk);
        #2 reg_reset_N = 1'b1;

        // reset state
        assert (keys_on == '0 && lsound_out == 0 && rsound_out == 0)
            else stop_with_error("outputs not zero after reset");
        cpu_access(1'b0, REG_CHANNEL, 8'h00, rd);
        assert (rd == 8'h00) else stop_with_error($sformatf("channel %0d, expected 0", rd));
        check_bend();
        cpu_access(1'b0, 4'd9, 8'h00, rd);      // unmapped
        assert (rd == 8'h00) else stop_with_error($sformatf("unmapped read %h", rd));

        // channel filter
        cpu_access(1'b1, REG_CHANNEL, 8'h03, rd);
        cpu_access(1'b0, REG_CHANNEL, 8'h00, rd);
        assert (rd == 8'h03) else stop_with_error($sformatf("channel %0d, expected 3", rd));
        play(8'h95, 7'd60, next_velocity(), 1'b0);
        play(8'h93, 7'd60, next_velocity(), 1'b0);

        // fill voices 1..7 under running status, ninth note is lost
        play(8'h93, 7'd62, next_velocity(), 1'b0);
        for (int i = 0; i < 6; i++)
            play(8'h93, 7'(64 + 2 * i), next_velocity(), 1'b1);
        play(8'h93, 7'd76, next_velocity(), 1'b1);
        cpu_access(1'b0, REG_KEYS, 8'h00, rd);
        assert (rd == 8'hFF) else stop_with_error($sformatf("key map %h, expected ff", rd));

        // release, then reuse of the lowest freed voice
        play(8'h83, 7'd64, 7'd64, 1'b0);
        play(8'h93, 7'd66, 7'd0, 1'b0);
        play(8'h93, 7'd90, next_velocity(), 1'b1);
        play(8'h93, 7'd60, next_velocity(), 1'b1);  // held key, new velocity
        cpu_access(1'b0, REG_KEYS, 8'h00, rd);
        assert (rd == model_keys()) else stop_with_error($sformatf("key map %h", rd));

        for (int i = 0; i < 40; i++)
            pulse_trig();

        // pitch bend, then audio with the wheel well below centre
        send_message(8'hE3, 8'h22, 8'h41, 1'b0);
        exp_bend = (14'h41 << 7) + 14'h22;
        expect_keys();
        check_bend();
        send_message(8'hE3, 8'h00, 8'h10, 1'b1);
        exp_bend = 14'h10 << 7;
        expect_keys();
        check_bend();
        for (int i = 0; i < 40; i++)
            pulse_trig();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: hw/synthesizer.sv
//////////////////////////////////////////////////////////////////////
// two channel midi synthesizer top; midi receive and decode, voice
// engine, square wave mixer and cpu registers, all on reg_clk
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module synthesizer
    import synth_pkg::*;
#(
    parameter int VOICES        = 8,
    parameter int CLKS_PER_BIT  = 32,
    parameter int EVT_DEPTH     = 4,
    parameter int AUD_BIT_DEPTH = 24,
    parameter int AMP_SHIFT     = 8
) (
    input  logic                            reg_clk,
    input  logic                            reg_reset_N,
    input  logic                            midi_rxd,       // idles high
    input  logic                            trig,           // sample strobe
    input  logic                            cpu_write,
    input  logic                            cpu_read,
    input  logic [3:0]                      cpu_address,
    input  logic [7:0]                      cpu_wdata,
    output logic [7:0]                      cpu_rdata,
    output logic [VOICES-1:0]               keys_on,
    output logic signed [AUD_BIT_DEPTH-1:0] lsound_out,
    output logic signed [AUD_BIT_DEPTH-1:0] rsound_out
);

    logic [7:0]              rx_byte;
    logic                    rx_valid;
    logic [3:0]              midi_ch;
    // decoder to engine
    logic                    evt_valid, evt_credit;
    evt_op_e                 evt_op;
    logic [KEY_W-1:0]        evt_key;
    logic [VEL_W-1:0]        evt_vel;
    logic [BEND_W-1:0]       evt_bend;
    // voice state
    logic [VOICES*KEY_W-1:0] voice_key;
    logic [VOICES*VEL_W-1:0] voice_vel;
    logic [BEND_W-1:0]       bend_val;

    //////////////////////////////////////////////////////////////////////
    // midi front end
    midi_uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) midi_uart_rx_inst (
        .reg_clk    (reg_clk),    .reg_reset_N (reg_reset_N),
        .midi_rxd   (midi_rxd),
        .rx_byte    (rx_byte),    .rx_valid    (rx_valid)
    );

    midi_decoder #(.EVT_DEPTH(EVT_DEPTH)) midi_decoder_inst (
        .reg_clk    (reg_clk),    .reg_reset_N (reg_reset_N),
        .rx_byte    (rx_byte),    .rx_valid    (rx_valid),
        .midi_ch    (midi_ch),    .evt_credit  (evt_credit),
        .evt_valid  (evt_valid),  .evt_op      (evt_op),
        .evt_key    (evt_key),    .evt_vel     (evt_vel),
        .evt_bend   (evt_bend)
    );

    //////////////////////////////////////////////////////////////////////
    // sound generation
    synth_engine #(.VOICES(VOICES), .EVT_DEPTH(EVT_DEPTH)) synth_engine_inst (
        .reg_clk    (reg_clk),    .reg_reset_N (reg_reset_N),
        .evt_valid  (evt_valid),  .evt_op      (evt_op),
        .evt_key    (evt_key),    .evt_vel     (evt_vel),
        .evt_bend   (evt_bend),   .evt_credit  (evt_credit),
        .voice_on   (keys_on),    // key map is the voice on vector
        .voice_key  (voice_key),  .voice_vel   (voice_vel),
        .bend_val   (bend_val)
    );

    voice_mixer #(
        .VOICES(VOICES), .PHASE_W(PHASE_W),
        .AUD_BIT_DEPTH(AUD_BIT_DEPTH), .AMP_SHIFT(AMP_SHIFT)
    ) voice_mixer_inst (
        .reg_clk    (reg_clk),    .reg_reset_N (reg_reset_N),
        .trig       (trig),       .voice_on    (keys_on),
        .voice_key  (voice_key),  .voice_vel   (voice_vel),
        .bend_val   (bend_val),
        .lsound_out (lsound_out), .rsound_out  (rsound_out)
    );

    // cpu side
    synth_regs #(.VOICES(VOICES)) synth_regs_inst (
        .reg_clk     (reg_clk),     .reg_reset_N (reg_reset_N),
        .cpu_write   (cpu_write),   .cpu_read    (cpu_read),
        .cpu_address (cpu_address), .cpu_wdata   (cpu_wdata),
        .keys_on     (keys_on),     .bend_val    (bend_val),
        .midi_ch     (midi_ch),     .cpu_rdata   (cpu_rdata)
    );

endmodule

// File: hw/synth_regs.sv
//////////////////////////////////////////////////////////////////////
// cpu register block; midi channel select plus read back of the key
// map and the current pitch bend
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module synth_regs
    import synth_pkg::*;
#(
    parameter int VOICES = 8
) (
    input  logic              reg_clk,
    input  logic              reg_reset_N,
    input  logic              cpu_write,
    input  logic              cpu_read,
    input  logic [3:0]        cpu_address,
    input  logic [7:0]        cpu_wdata,
    input  logic [VOICES-1:0] keys_on,
    input  logic [BEND_W-1:0] bend_val,
    output logic [3:0]        midi_ch,
    output logic [7:0]        cpu_rdata
);

    // only REG_CHANNEL is writable
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N)
            midi_ch <= 4'h0;
        else if (cpu_write && cpu_address == REG_CHANNEL)
            midi_ch <= cpu_wdata[3:0];
    end

    // read data lands a cycle after cpu_read, held until the next read
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            cpu_rdata <= 8'h00;
        end else if (cpu_read) begin
            case (cpu_address)
                REG_CHANNEL: cpu_rdata <= {4'h0, midi_ch};
                REG_KEYS:    cpu_rdata <= 8'(keys_on);          // voices 7..0
                REG_BEND_LO: cpu_rdata <= {1'b0, bend_val[6:0]};
                REG_BEND_HI: cpu_rdata <= {1'b0, bend_val[13:7]};
                default:     cpu_rdata <= 8'h00;                // unmapped
            endcase
        end
    end

endmodule

// File: hw/voice_mixer.sv
//////////////////////////////////////////////////////////////////////
// square wave voices; phases step on trig, even voices sum left and
// odd voices sum right into registered audio samples
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module voice_mixer
    import synth_pkg::*;
#(
    parameter int VOICES        = 8,
    parameter int PHASE_W       = 16,
    parameter int AUD_BIT_DEPTH = 24,
    parameter int AMP_SHIFT     = 8
) (
    input  logic                            reg_clk,
    input  logic                            reg_reset_N,
    input  logic                            trig,
    input  logic [VOICES-1:0]               voice_on,
    input  logic [VOICES*KEY_W-1:0]         voice_key,
    input  logic [VOICES*VEL_W-1:0]         voice_vel,
    input  logic [BEND_W-1:0]               bend_val,
    output logic signed [AUD_BIT_DEPTH-1:0] lsound_out,
    output logic signed [AUD_BIT_DEPTH-1:0] rsound_out
);

    logic [PHASE_W-1:0]              phase [VOICES];
    logic signed [BEND_W:0]          bend_off;      // -8192..8191
    logic [PHASE_W-1:0]              bend_step;
    logic signed [AUD_BIT_DEPTH-1:0] amp;
    logic signed [AUD_BIT_DEPTH-1:0] l_sum, r_sum;

    assign bend_off  = $signed({1'b0, bend_val}) - $signed({1'b0, BEND_CENTER});
    assign bend_step = PHASE_W'(bend_off >>> 9);    // sign extended, +-16

    // step = (key + 1) << 4 plus bend, idle voices park at zero
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            for (int i = 0; i < VOICES; i++)
                phase[i] <= '0;
        end else if (trig) begin
            for (int i = 0; i < VOICES; i++)
                phase[i] <= voice_on[i] ?
                    phase[i] + ((PHASE_W'(voice_key[i*KEY_W +: KEY_W]) + 1'b1) << 4)
                             + bend_step : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sample sum, from the phase held when trig arrives
    always_comb begin
        l_sum = '0;
        r_sum = '0;
        amp   = '0;
        for (int i = 0; i < VOICES; i++) begin
            amp = AUD_BIT_DEPTH'(voice_vel[i*VEL_W +: VEL_W]) << AMP_SHIFT;
            if (!voice_on[i])
                amp = '0;
            else if (phase[i][PHASE_W-1])
                amp = -amp;                 // low half of the square
            if (i % 2 == 0)
                l_sum = l_sum + amp;
            else
                r_sum = r_sum + amp;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            lsound_out <= '0;
            rsound_out <= '0;
        end else if (trig) begin
            lsound_out <= l_sum;
            rsound_out <= r_sum;
        end
    end

endmodule

// File: hw/synth_engine.sv
//////////////////////////////////////////////////////////////////////
// voice engine; queues note events, pops one per cycle, allocates the
// lowest free voice and holds the pitch bend value
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module synth_engine
    import synth_pkg::*;
#(
    parameter int VOICES    = 8,
    parameter int EVT_DEPTH = 4
) (
    input  logic                    reg_clk,
    input  logic                    reg_reset_N,
    input  logic                    evt_valid,
    input  evt_op_e                 evt_op,
    input  logic [KEY_W-1:0]        evt_key,
    input  logic [VEL_W-1:0]        evt_vel,
    input  logic [BEND_W-1:0]       evt_bend,
    output logic                    evt_credit,
    output logic [VOICES-1:0]       voice_on,
    output logic [VOICES*KEY_W-1:0] voice_key,
    output logic [VOICES*VEL_W-1:0] voice_vel,
    output logic [BEND_W-1:0]       bend_val
);

    localparam int PTR_W = $clog2(EVT_DEPTH);
    localparam int CNT_W = $clog2(EVT_DEPTH + 1);
    localparam int IDX_W = $clog2(VOICES);

    // event queue
    evt_op_e           q_op   [EVT_DEPTH];
    logic [KEY_W-1:0]  q_key  [EVT_DEPTH];
    logic [VEL_W-1:0]  q_vel  [EVT_DEPTH];
    logic [BEND_W-1:0] q_bend [EVT_DEPTH];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic              pop;

    // allocator
    logic              free_hit, key_hit;
    logic [IDX_W-1:0]  free_idx, key_idx;
    logic              claim, refresh, dup_key;

    assign pop        = q_count != '0;
    assign evt_credit = pop;                // credit back per pop

    always_ff @(posedge reg_clk) begin
        if (evt_valid) begin
            q_op[wr_ptr]   <= evt_op;
            q_key[wr_ptr]  <= evt_key;
            q_vel[wr_ptr]  <= evt_vel;
            q_bend[wr_ptr] <= evt_bend;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (evt_valid)
                wr_ptr <= (wr_ptr == PTR_W'(EVT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(EVT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            q_count <= q_count + CNT_W'(evt_valid) - CNT_W'(pop);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lowest free voice, and any voice already on this key
    always_comb begin
        free_hit = 1'b0;
        free_idx = '0;
        key_hit  = 1'b0;
        key_idx  = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin   // downward, lowest wins
            if (!voice_on[i]) begin
                free_hit = 1'b1;
                free_idx = IDX_W'(i);
            end
            if (voice_on[i] && voice_key[i*KEY_W +: KEY_W] == q_key[rd_ptr]) begin
                key_hit = 1'b1;
                key_idx = IDX_W'(i);
            end
        end
    end

    assign claim   = pop && q_op[rd_ptr] == EVT_NOTE_ON && !key_hit && free_hit;
    assign refresh = pop && q_op[rd_ptr] == EVT_NOTE_ON && key_hit;

    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            voice_on <= '0;
            bend_val <= BEND_CENTER;
        end else begin
            if (claim)
                voice_on[free_idx] <= 1'b1;
            if (pop && q_op[rd_ptr] == EVT_NOTE_OFF) begin
                for (int i = 0; i < VOICES; i++)
                    if (voice_key[i*KEY_W +: KEY_W] == q_key[rd_ptr])
                        voice_on[i] <= 1'b0;
            end
            if (pop && q_op[rd_ptr] == EVT_BEND)
                bend_val <= q_bend[rd_ptr];
        end
    end

    always_ff @(posedge reg_clk) begin
        if (claim) begin
            voice_key[free_idx*KEY_W +: KEY_W] <= q_key[rd_ptr];
            voice_vel[free_idx*VEL_W +: VEL_W] <= q_vel[rd_ptr];
        end
        if (refresh)
            voice_vel[key_idx*VEL_W +: VEL_W] <= q_vel[rd_ptr];  // retrigger
    end

    always_comb begin
        dup_key = 1'b0;
        for (int i = 0; i < VOICES; i++)
            for (int j = i + 1; j < VOICES; j++)
                if (voice_on[i] && voice_on[j] &&
                    voice_key[i*KEY_W +: KEY_W] == voice_key[j*KEY_W +: KEY_W])
                    dup_key = 1'b1;
    end

    a_no_overflow : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        evt_valid |-> q_count != CNT_W'(EVT_DEPTH));
    a_unique_keys : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        !dup_key);

endmodule

// File: hw/midi_decoder.sv
//////////////////////////////////////////////////////////////////////
// midi message parser; filters one channel, keeps running status and
// sends note and bend events to the engine against a credit count
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module midi_decoder
    import synth_pkg::*;
#(
    parameter int EVT_DEPTH = 4
) (
    input  logic              reg_clk,
    input  logic              reg_reset_N,
    input  logic [7:0]        rx_byte,
    input  logic              rx_valid,
    input  logic [3:0]        midi_ch,
    input  logic              evt_credit,
    output logic              evt_valid,
    output evt_op_e           evt_op,
    output logic [KEY_W-1:0]  evt_key,
    output logic [VEL_W-1:0]  evt_vel,
    output logic [BEND_W-1:0] evt_bend
);

    localparam int CRED_W = $clog2(EVT_DEPTH + 1);

    dec_state_e        state;
    logic [3:0]        status_hi;           // 8, 9 or E while not idle
    logic [6:0]        data1;
    logic [CRED_W-1:0] credits;
    logic              is_status;
    logic              is_realtime;
    logic              msg_done;
    logic              send;

    assign is_realtime = rx_byte >= 8'hF8;
    assign is_status   = rx_byte[7];
    assign msg_done    = rx_valid && !is_status && state == ST_DATA2;
    assign send        = msg_done && credits != '0;   // no credit, message lost

    //////////////////////////////////////////////////////////////////////
    // status and data byte tracking
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            state     <= ST_IDLE;
            status_hi <= 4'h0;
        end else if (rx_valid && !is_realtime) begin
            if (is_status) begin
                status_hi <= rx_byte[7:4];
                if ((rx_byte[7:4] == 4'h8 || rx_byte[7:4] == 4'h9 ||
                     rx_byte[7:4] == 4'hE) && rx_byte[3:0] == midi_ch)
                    state <= ST_DATA1;
                else
                    state <= ST_IDLE;       // foreign or unhandled status
            end else begin
                case (state)
                    ST_DATA1: state <= ST_DATA2;
                    ST_DATA2: state <= ST_DATA1;    // running status
                    default:  state <= ST_IDLE;     // stray data byte
                endcase
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rx_valid && !is_status && state == ST_DATA1)
            data1 <= rx_byte[6:0];
    end

    //////////////////////////////////////////////////////////////////////
    // event out
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N)
            evt_valid <= 1'b0;
        else
            evt_valid <= send;
    end

    always_ff @(posedge reg_clk) begin
        if (msg_done) begin
            evt_key  <= data1;
            evt_vel  <= rx_byte[6:0];
            evt_bend <= {rx_byte[6:0], data1};      // msb data byte second
            case (status_hi)
                4'h9:    evt_op <= (rx_byte[6:0] == 7'd0) ? EVT_NOTE_OFF : EVT_NOTE_ON;
                4'hE:    evt_op <= EVT_BEND;
                default: evt_op <= EVT_NOTE_OFF;
            endcase
        end
    end

    // one credit per event, returned when the engine pops it
    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N)
            credits <= CRED_W'(EVT_DEPTH);
        else
            credits <= credits - CRED_W'(send) + CRED_W'(evt_credit);
    end

    a_credit_max : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        credits <= CRED_W'(EVT_DEPTH));

endmodule

// File: hw/midi_uart_rx.sv
//////////////////////////////////////////////////////////////////////
// serial midi receiver, 8N1 at CLKS_PER_BIT reg_clk cycles per bit;
// hands each good byte to the decoder as a one cycle pulse
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module midi_uart_rx #(
    parameter int CLKS_PER_BIT = 32
) (
    input  logic       reg_clk,
    input  logic       reg_reset_N,
    input  logic       midi_rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [1:0]       rx_sync;              // metastability pair
    logic             busy;
    logic [3:0]       bit_idx;              // 0 start, 1..8 data, 9 stop
    logic [CNT_W-1:0] cnt;                  // cycles to next sample point
    logic [7:0]       shift_q;

    always_ff @(posedge reg_clk) begin
        if (!reg_reset_N) begin
            rx_sync  <= 2'b11;              // line idles high
            busy     <= 1'b0;
            bit_idx  <= '0;
            cnt      <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], midi_rxd};
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync[1]) begin      // falling edge of start bit
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    cnt     <= CNT_W'(CLKS_PER_BIT / 2 - 1);   // aim at mid bit
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt     <= CNT_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync[1])
                    busy <= 1'b0;           // glitch, not a start bit
                if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync[1]; // framing error drops the byte
                end
            end
        end
    end

    // data bits, lsb first
    always_ff @(posedge reg_clk) begin
        if (busy && cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9)
            shift_q <= {rx_sync[1], shift_q[7:1]};
    end

    assign rx_byte = shift_q;               // stable through the stop bit

    a_valid_pulse : assert property (@(posedge reg_clk) disable iff (!reg_reset_N)
        rx_valid |=> !rx_valid);

endmodule

// File: hw/synth_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, event opcodes, decoder states and register map for
// the two channel synthesizer; imported by the modules that need them
//////////////////////////////////////////////////////////////////////
package synth_pkg;

    // midi field widths
    localparam int KEY_W   = 7;
    localparam int VEL_W   = 7;
    localparam int BEND_W  = 14;
    localparam int PHASE_W = 16;            // oscillator accumulator

    localparam logic [BEND_W-1:0] BEND_CENTER = 14'd8192;   // wheel at rest

    // note events, decoder to engine
    typedef enum logic [1:0] {
        EVT_NOTE_ON  = 2'd0,
        EVT_NOTE_OFF = 2'd1,
        EVT_BEND     = 2'd2
    } evt_op_e;

    // message collector
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,                    // no running status held
        ST_DATA1 = 2'd1,
        ST_DATA2 = 2'd2
    } dec_state_e;

    //////////////////////////////////////////////////////////////////////
    // cpu register map
    localparam logic [3:0] REG_CHANNEL = 4'd0;  // rw, low nibble
    localparam logic [3:0] REG_KEYS    = 4'd1;  // ro
    localparam logic [3:0] REG_BEND_LO = 4'd2;  // ro, bend[6:0]
    localparam logic [3:0] REG_BEND_HI = 4'd3;  // ro, bend[13:7]

endpackage
